// File: logic/l2_macros.svh
// geometry is fixed at 4 ways and sizes must be powers of two for the address split
`ifndef L2_MACROS_SVH
`define L2_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// cache geometry
////////////////////////////////////////////////////////////////////////////

`define L2_WORD_W        32           // data word width in bits

`define L2_BLOCK_WORDS   4            // words per block

`define L2_ASSOC         4            // ways per set

`define L2_SETS          8            // sets in the cache

////////////////////////////////////////////////////////////////////////////
// address map
////////////////////////////////////////////////////////////////////////////

// every access at or above this address bypasses the cache
`define L2_NONCACHE_BASE 32'h8000_0000

`endif

// File: logic/l2_pkg.sv
// field widths follow the geometry macros and assume a 32-bit byte address
`include "l2_macros.svh"

package l2_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // bus vectors
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [`L2_WORD_W-1:0]   word_t;
    typedef logic [31:0]             addr_t;     // byte address
    typedef logic [`L2_WORD_W/8-1:0] byte_en_t;  // one bit per byte lane

    ////////////////////////////////////////////////////////////////////////////
    // address fields and way numbers
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [$clog2(`L2_SETS)-1:0]        set_idx_t;   // addr bits 6..4
    typedef logic [$clog2(`L2_BLOCK_WORDS)-1:0] word_idx_t;  // addr bits 3..2
    typedef logic [$clog2(`L2_ASSOC)-1:0]       way_t;

    // tag is what is left above set, word and byte offset
    typedef logic [31-$clog2(`L2_SETS)-$clog2(`L2_BLOCK_WORDS)-2:0] tag_t;

    // miss sequencer
    typedef enum logic [1:0] {
        IDLE,       // hits and pass-through complete here
        WRITEBACK,  // dirty victim goes out word by word
        FETCH       // new block comes in word by word
    } l2_state_t;

endpackage

// File: logic/l2_tag_array.sv
// the request address must stay stable through a miss since set and tag come from it
`timescale 1ns/1ps
`include "l2_macros.svh"

module l2_tag_array (
    input  logic                CLK,
    input  logic                nRST,
    input  l2_pkg::addr_t       proc_addr,
    output logic                hit,
    output l2_pkg::way_t        hit_way,
    output l2_pkg::word_t       hit_rdata,
    input  l2_pkg::way_t        victim_way,
    output logic                victim_dirty,
    output l2_pkg::tag_t        victim_tag,
    input  l2_pkg::word_idx_t   wb_word,
    output l2_pkg::word_t       victim_rdata,
    input  logic                hit_write,
    input  l2_pkg::word_t       write_data,
    input  l2_pkg::byte_en_t    write_byte_en,
    input  logic                fill_write,
    input  l2_pkg::word_t       fill_data,
    input  logic                fill_done,
    input  logic                clean_victim
);
    import l2_pkg::*;

    logic [`L2_ASSOC-1:0] valid [`L2_SETS];
    logic [`L2_ASSOC-1:0] dirty [`L2_SETS];
    tag_t                 tags  [`L2_SETS][`L2_ASSOC];
    word_t                data  [`L2_SETS][`L2_ASSOC][`L2_BLOCK_WORDS];

    word_idx_t            word_idx;
    set_idx_t             set_idx;
    tag_t                 addr_tag;
    logic [`L2_ASSOC-1:0] hit_vec;
    word_t                merged;

    assign word_idx = proc_addr[2 +: $bits(word_idx_t)];
    assign set_idx  = proc_addr[2 + $bits(word_idx_t) +: $bits(set_idx_t)];
    assign addr_tag = proc_addr[$bits(addr_t)-1 -: $bits(tag_t)];

    ////////////////////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        hit_way = '0;
        for (int i = 0; i < `L2_ASSOC; i++) begin
            hit_vec[i] = valid[set_idx][i] && (tags[set_idx][i] == addr_tag);
            if (hit_vec[i]) begin
                hit_way = way_t'(i);
            end
        end
    end

    assign hit          = |hit_vec;
    assign hit_rdata    = data[set_idx][hit_way][word_idx];
    assign victim_dirty = valid[set_idx][victim_way] && dirty[set_idx][victim_way];
    assign victim_tag   = tags[set_idx][victim_way];
    assign victim_rdata = data[set_idx][victim_way][wb_word];

    // byte merge for write hits
    always_comb begin
        merged = hit_rdata;
        for (int b = 0; b < $bits(byte_en_t); b++) begin
            if (write_byte_en[b]) begin
                merged[8*b +: 8] = write_data[8*b +: 8];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // updates
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < `L2_SETS; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
            end
        end else begin
            if (hit_write)    dirty[set_idx][hit_way]    <= 1'b1;
            if (clean_victim) dirty[set_idx][victim_way] <= 1'b0;  // after last wb word
            if (fill_done)    valid[set_idx][victim_way] <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (hit_write)  data[set_idx][hit_way][word_idx]   <= merged;
        if (fill_write) data[set_idx][victim_way][wb_word] <= fill_data;
        if (fill_done)  tags[set_idx][victim_way]          <= addr_tag;
    end

    assert property (@(posedge CLK) disable iff (!nRST) $onehot0(hit_vec))
        else $error("several ways hit in set %0d", set_idx);

    assert property (@(posedge CLK) disable iff (!nRST) !(hit_write && fill_write))
        else $error("hit write and fill write in the same cycle");

endmodule

// File: logic/l2_replacement.sv
// true lru for 4 ways and the order only changes on touch so the victim holds through a miss
`timescale 1ns/1ps
`include "l2_macros.svh"

module l2_replacement (
    input  logic          CLK,
    input  logic          nRST,
    input  l2_pkg::addr_t proc_addr,
    input  logic          touch,
    input  l2_pkg::way_t  touch_way,
    output l2_pkg::way_t  victim_way
);
    import l2_pkg::*;

    way_t     order [`L2_SETS][`L2_ASSOC];  // least recent first
    way_t     next_order [`L2_ASSOC];
    set_idx_t set_idx;
    logic     shift;

    assign set_idx    = proc_addr[2 + $bits(word_idx_t) +: $bits(set_idx_t)];
    assign victim_way = order[set_idx][0];

    // pull touched way out and append it at the tail
    always_comb begin
        shift = 1'b0;
        for (int i = 0; i < `L2_ASSOC - 1; i++) begin
            if (order[set_idx][i] == touch_way) begin
                shift = 1'b1;
            end
            next_order[i] = shift ? order[set_idx][i+1] : order[set_idx][i];
        end
        next_order[`L2_ASSOC-1] = touch_way;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < `L2_SETS; s++) begin
                for (int i = 0; i < `L2_ASSOC; i++) begin
                    order[s][i] <= way_t'(i);  // way 0 is first victim
                end
            end
        end else if (touch) begin
            for (int i = 0; i < `L2_ASSOC; i++) begin
                order[set_idx][i] <= next_order[i];
            end
        end
    end

    for (genvar s = 0; s < `L2_SETS; s++) begin : g_perm_check
        logic [`L2_ASSOC-1:0] seen;

        always_comb begin
            seen = '0;
            for (int i = 0; i < `L2_ASSOC; i++) begin
                seen[order[s][i]] = 1'b1;
            end
        end

        assert property (@(posedge CLK) disable iff (!nRST) &seen)
            else $error("lru order of set %0d lost a way", s);
    end

endmodule

// File: logic/l2_controller.sv
// one access in flight and the processor holds it until proc_busy drops
`timescale 1ns/1ps
`include "l2_macros.svh"

module l2_controller (
    input  logic              CLK,
    input  logic              nRST,
    input  l2_pkg::addr_t     proc_addr,
    input  l2_pkg::word_t     proc_wdata,
    input  l2_pkg::byte_en_t  proc_byte_en,
    input  logic              proc_ren,
    input  logic              proc_wen,
    output l2_pkg::word_t     proc_rdata,
    output logic              proc_busy,
    output l2_pkg::addr_t     mem_addr,
    output l2_pkg::word_t     mem_wdata,
    output l2_pkg::byte_en_t  mem_byte_en,
    output logic              mem_ren,
    output logic              mem_wen,
    input  l2_pkg::word_t     mem_rdata,
    input  logic              mem_busy,
    input  logic              hit,
    input  l2_pkg::way_t      hit_way,
    input  l2_pkg::word_t     hit_rdata,
    input  l2_pkg::way_t      victim_way,
    input  logic              victim_dirty,
    input  l2_pkg::tag_t      victim_tag,
    input  l2_pkg::word_t     victim_rdata,
    output l2_pkg::word_idx_t wb_word,
    output logic              hit_write,
    output logic              fill_write,
    output logic              fill_done,
    output logic              clean_victim,
    output l2_pkg::word_t     write_data,
    output l2_pkg::word_t     fill_data,
    output l2_pkg::byte_en_t  write_byte_en,
    output logic              touch,
    output l2_pkg::way_t      touch_way
);
    import l2_pkg::*;

    localparam int OFFSET_W = $bits(word_idx_t) + 2;  // word plus byte offset

    l2_state_t state, next_state;
    word_idx_t word_cnt;
    addr_t     mar;                                   // memory address register
    logic      req, noncache, miss, last_word, advance;
    set_idx_t  addr_set;
    addr_t     wb_base, fetch_base;

    assign req        = proc_ren || proc_wen;
    assign noncache   = proc_addr >= addr_t'(`L2_NONCACHE_BASE);
    assign miss       = (state == IDLE) && req && !noncache && !hit;
    assign last_word  = word_cnt == word_idx_t'(`L2_BLOCK_WORDS - 1);
    assign advance    = (state != IDLE) && !mem_busy;   // one word per free mem cycle
    assign addr_set   = proc_addr[OFFSET_W +: $bits(set_idx_t)];
    assign wb_base    = {victim_tag, addr_set, OFFSET_W'(0)};
    assign fetch_base = {proc_addr[$bits(addr_t)-1:OFFSET_W], OFFSET_W'(0)};

    assign wb_word       = word_cnt;
    assign write_data    = proc_wdata;
    assign write_byte_en = proc_byte_en;
    assign fill_data     = mem_rdata;
    assign touch_way     = hit_way;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state    <= IDLE;
            word_cnt <= '0;
        end else begin
            state <= next_state;
            if (advance) begin
                word_cnt <= last_word ? '0 : word_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (miss) begin
            mar <= victim_dirty ? wb_base : fetch_base;
        end else if (advance) begin
            mar <= (state == WRITEBACK && last_word) ? fetch_base : mar + addr_t'(4);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // next state and bus steering
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        next_state   = state;
        proc_busy    = 1'b1;
        proc_rdata   = noncache ? mem_rdata : hit_rdata;
        mem_addr     = mar;
        mem_wdata    = victim_rdata;
        mem_byte_en  = '1;                             // block moves use whole words
        mem_ren      = 1'b0;
        mem_wen      = 1'b0;
        hit_write    = 1'b0;
        fill_write   = 1'b0;
        fill_done    = 1'b0;
        clean_victim = 1'b0;
        touch        = 1'b0;
        case (state)
            IDLE: begin
                if (req && noncache) begin
                    mem_addr    = proc_addr;           // straight through to memory
                    mem_wdata   = proc_wdata;
                    mem_byte_en = proc_byte_en;
                    mem_ren     = proc_ren;
                    mem_wen     = proc_wen;
                    proc_busy   = mem_busy;
                end else if (req && hit) begin
                    proc_busy = 1'b0;
                    touch     = 1'b1;
                    hit_write = proc_wen;
                end else if (miss) begin
                    next_state = victim_dirty ? WRITEBACK : FETCH;
                end
            end
            WRITEBACK: begin
                mem_wen = 1'b1;
                if (advance && last_word) begin
                    clean_victim = 1'b1;
                    next_state   = FETCH;
                end
            end
            FETCH: begin
                mem_ren    = 1'b1;
                fill_write = advance;
                if (advance && last_word) begin
                    fill_done  = 1'b1;
                    next_state = IDLE;                 // access then completes as a hit
                end
            end
            default: next_state = IDLE;
        endcase
    end

    assert property (@(posedge CLK) disable iff (!nRST) !(proc_ren && proc_wen))
        else $error("read and write requested together");

    // replacement must not move the victim under a running miss
    assert property (@(posedge CLK) disable iff (!nRST) (state != IDLE) |-> $stable(victim_way))
        else $error("victim way changed during a miss");

endmodule

// File: logic/l2_cache.sv
// 4-way write-back cache that serves one held request at a time on busy-based word buses
`timescale 1ns/1ps

module l2_cache (
    input  logic             CLK,
    input  logic             nRST,
    // processor side
    input  l2_pkg::addr_t    proc_addr,
    input  l2_pkg::word_t    proc_wdata,
    input  l2_pkg::byte_en_t proc_byte_en,
    input  logic             proc_ren,
    input  logic             proc_wen,
    output l2_pkg::word_t    proc_rdata,
    output logic             proc_busy,
    // memory side
    output l2_pkg::addr_t    mem_addr,
    output l2_pkg::word_t    mem_wdata,
    output l2_pkg::byte_en_t mem_byte_en,
    output logic             mem_ren,
    output logic             mem_wen,
    input  l2_pkg::word_t    mem_rdata,
    input  logic             mem_busy
);
    import l2_pkg::*;

    // lookup results
    logic      hit;
    way_t      hit_way;
    word_t     hit_rdata;
    way_t      victim_way;
    logic      victim_dirty;
    tag_t      victim_tag;
    word_t     victim_rdata;

    // array update controls
    word_idx_t wb_word;
    logic      hit_write;
    logic      fill_write;
    logic      fill_done;
    logic      clean_victim;
    word_t     write_data;
    word_t     fill_data;
    byte_en_t  write_byte_en;

    // replacement update
    logic      touch;
    way_t      touch_way;

    l2_tag_array u_tag_array (.*);     // frames and hit compare

    l2_replacement u_replacement (.*); // per-set lru order

    l2_controller u_controller (.*);   // miss fsm and bus steering

endmodule

// File: tests/l2_mem_model.sv
// word memory for the testbench that only maps address bit 31 and bits 9..0 of each request
`timescale 1ns/1ps

module l2_mem_model (
    input  logic             CLK,
    input  logic             nRST,
    input  l2_pkg::addr_t    mem_addr,
    input  l2_pkg::word_t    mem_wdata,
    input  l2_pkg::byte_en_t mem_byte_en,
    input  logic             mem_ren,
    input  logic             mem_wen,
    output l2_pkg::word_t    mem_rdata,
    output logic             mem_busy
);
    logic [7:0]  store [2048];  // byte store, peeked by the testbench
    int          xfers;         // completed word transfers
    logic [1:0]  wait_cnt;      // busy cycles left for this word
    integer      seed;
    logic [10:0] base;
    logic        req;

    assign req       = mem_ren || mem_wen;
    assign base      = {mem_addr[31], mem_addr[9:2], 2'b00};
    assign mem_busy  = !req || (wait_cnt != 2'd0);
    assign mem_rdata = {store[base + 11'd3], store[base + 11'd2],
                        store[base + 11'd1], store[base]};

    initial begin
        logic [31:0] hash;
        seed = 23;
        for (int i = 0; i < 2048; i++) begin
            hash     = {i[10], 21'd0, i[9:0]} * 32'h9e37_79b1;  // mixes every address bit
            store[i] = hash[31:24];
        end
    end

    always @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= 2'd0;
            xfers    <= 0;
        end else if (req) begin
            if (wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end else begin
                wait_cnt <= 2'($random(seed));  // stretch for the next word
                xfers    <= xfers + 1;
                for (int b = 0; b < 4; b++) begin
                    if (mem_wen && mem_byte_en[b]) store[base + b] <= mem_wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: tests/l2_cache_tb.sv
// random accesses against a byte model and all addresses stay inside the memory model's map
`timescale 1ns/1ps
`include "l2_macros.svh"

module l2_cache_tb;
    import l2_pkg::*;

    localparam int     N_ACCESS     = 400;                // random part of the run
    localparam int     MAX_ACCESSES = 2 * N_ACCESS + 16;  // plus directed and readback
    localparam longint LIMIT_CYCLES = MAX_ACCESSES * (2 * `L2_BLOCK_WORDS * 4 + 2) + 8;

    logic     CLK;
    logic     nRST;
    addr_t    proc_addr;
    word_t    proc_wdata;
    byte_en_t proc_byte_en;
    logic     proc_ren;
    logic     proc_wen;
    word_t    proc_rdata;
    logic     proc_busy;
    addr_t    mem_addr;
    word_t    mem_wdata;
    byte_en_t mem_byte_en;
    logic     mem_ren;
    logic     mem_wen;
    word_t    mem_rdata;
    logic     mem_busy;

    logic [7:0] model [2048];  // expected bytes, same map as the memory
    addr_t      written [$];
    integer     seed;

    l2_cache uut (.*);

    l2_mem_model u_mem (.*);

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    initial begin
        #(LIMIT_CYCLES * 20);
        $display("watchdog expired before all accesses completed");
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

    ////////////////////////////////////////////////////////////////////////////
    // model access and checking
    ////////////////////////////////////////////////////////////////////////////

    function automatic int slot(addr_t a);
        return {a[31], a[9:2], 2'b00};
    endfunction

    function automatic word_t model_word(addr_t a);
        int s;
        s = slot(a);
        return {model[s+3], model[s+2], model[s+1], model[s]};
    endfunction

    function automatic word_t mem_word(addr_t a);
        int s;
        s = slot(a);
        return {u_mem.store[s+3], u_mem.store[s+2], u_mem.store[s+1], u_mem.store[s]};
    endfunction

    function automatic int unsigned rnd(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // mostly six tags per set so that sets overflow
    function automatic addr_t random_addr();
        if (rnd(8) == 0) begin
            return `L2_NONCACHE_BASE + 4 * rnd(64);
        end
        return {tag_t'(rnd(6)), set_idx_t'(rnd(`L2_SETS)),
                word_idx_t'(rnd(`L2_BLOCK_WORDS)), 2'b00};
    endfunction

    task automatic check(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
            $display("Simulation failed");
            $fatal(1, "mismatch");
        end
    endtask

    // called at a falling edge, returns at the falling edge after completion
    task automatic bus_access(input logic wr, input addr_t a, input word_t d,
                              input byte_en_t be, output word_t rd, output logic busy_at_req);
        proc_addr    = a;
        proc_wdata   = d;
        proc_byte_en = be;
        proc_ren     = !wr;
        proc_wen     = wr;
        @(posedge CLK);
        busy_at_req = proc_busy;
        while (proc_busy) begin
            @(posedge CLK);
        end
        rd = proc_rdata;
        @(negedge CLK);
        proc_ren = 1'b0;
        proc_wen = 1'b0;
    endtask

    task automatic write_access(input addr_t a, input word_t d, input byte_en_t be);
        word_t rd;
        logic  busy_at_req;
        int    s;
        bus_access(1'b1, a, d, be, rd, busy_at_req);
        s = slot(a);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) model[s + b] = d[8*b +: 8];
        end
        written.push_back(a);
    endtask

    task automatic read_access(input addr_t a, output logic busy_at_req);
        word_t rd;
        bus_access(1'b0, a, '0, '0, rd, busy_at_req);
        check("proc_rdata", rd, model_word(a));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        addr_t a;
        logic  busy_at_req;
        logic  last_cached_read;
        int    xfers_before;
        seed         = 23;
        nRST         = 1'b0;
        proc_addr    = '0;
        proc_wdata   = '0;
        proc_byte_en = '0;
        proc_ren     = 1'b0;
        proc_wen     = 1'b0;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        for (int i = 0; i < 2048; i++) begin
            model[i] = u_mem.store[i];  // start from the memory's fill pattern
        end
        check("mem_ren", mem_ren, 1'b0);
        check("mem_wen", mem_wen, 1'b0);
        check("proc_busy", proc_busy, 1'b1);

        // five tags in set 5, the fifth evicts the dirty first line
        for (int t = 0; t < 5; t++) begin
            write_access({tag_t'(t), set_idx_t'(5), 4'h0}, $random(seed), 4'hf);
        end
        read_access({tag_t'(0), set_idx_t'(5), 4'h0}, busy_at_req);
        for (int w = 0; w < `L2_BLOCK_WORDS; w++) begin
            a = {tag_t'(0), set_idx_t'(5), word_idx_t'(w), 2'b00};
            check("mem store word", mem_word(a), model_word(a));
        end

        last_cached_read = 1'b0;
        a                = '0;
        for (int n = 0; n < N_ACCESS; n++) begin
            if (last_cached_read && rnd(4) == 0) begin
                read_access(a, busy_at_req);     // line is resident now
                check("proc_busy", busy_at_req, 1'b0);
            end else begin
                a = random_addr();
                if (rnd(2) == 0) begin
                    read_access(a, busy_at_req);
                    last_cached_read = a < `L2_NONCACHE_BASE;
                end else begin
                    xfers_before = u_mem.xfers;
                    write_access(a, $random(seed), byte_en_t'(rnd(16)));
                    last_cached_read = 1'b0;
                    if (a >= `L2_NONCACHE_BASE) begin
                        check("mem store word", mem_word(a), model_word(a));
                        check("mem transfers", u_mem.xfers - xfers_before, 1);
                    end
                end
            end
        end

        foreach (written[i]) begin
            read_access(written[i], busy_at_req);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: src.f
+incdir+logic
logic/l2_pkg.sv
logic/l2_tag_array.sv
logic/l2_replacement.sv
logic/l2_controller.sv
logic/l2_cache.sv
tests/l2_mem_model.sv
tests/l2_cache_tb.sv

// File: Bender.yml
package:
  name: l2_cache

sources:
  - include_dirs:
      - logic
    files:
      - logic/l2_pkg.sv
      - logic/l2_tag_array.sv
      - logic/l2_replacement.sv
      - logic/l2_controller.sv
      - logic/l2_cache.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/l2_mem_model.sv
      - tests/l2_cache_tb.sv
